//--- hw/matmul_pkg.sv
package matmul_pkg;

    ////////////////////////////////
    // Array geometry and timing
    ////////////////////////////////

    localparam int MAT_SIZE = 4;

    // Registers from operand input to accumulator inside one PE
    localparam int MAC_STAGES = 3;

    // Last count of a run. Done follows one cycle later
    localparam int DONE_CYCLE = 14 + MAC_STAGES;

    // First count at which every accumulator holds its final sum
    localparam int CAPTURE_CYCLE = 3 * MAT_SIZE - 1 + MAC_STAGES;

    ////////////////////////////////
    // Types
    ////////////////////////////////

    typedef logic [7:0]  data_t;
    typedef logic [31:0] word_t;
    typedef logic [9:0]  addr_t;
    typedef logic [7:0]  stride_t;
    typedef logic [7:0]  cycle_t;

    typedef struct packed {
        addr_t   base;
        stride_t stride;
    } mat_loc_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  we;
    } mem_req_t;

    // Element i sits in byte i, the same order as a memory word
    typedef data_t [MAT_SIZE-1:0] row_t;

endpackage

//--- hw/word_ram.sv
`timescale 1ns/10ps

module word_ram (
    input  logic                 clk,
    input  matmul_pkg::mem_req_t port0,
    input  matmul_pkg::mem_req_t port1,
    output matmul_pkg::word_t    q0,
    output matmul_pkg::word_t    q1
);

    localparam int DEPTH = 2 ** $bits(matmul_pkg::addr_t);

    matmul_pkg::word_t mem [DEPTH];

    // Both ports see old data on a read during write to the same address.
    // If both ports write one address in the same cycle, port 1 wins
    always_ff @(posedge clk) begin
        if (port0.we) begin
            mem[port0.addr] <= port0.wdata;
        end
        if (port1.we) begin
            mem[port1.addr] <= port1.wdata;
        end
        q0 <= mem[port0.addr];
        q1 <= mem[port1.addr];
    end

endmodule

//--- hw/processing_element.sv
`timescale 1ns/10ps

module processing_element (
    input  logic              clk,
    input  logic              clear,
    input  matmul_pkg::data_t in_a,
    input  matmul_pkg::data_t in_b,
    output matmul_pkg::data_t out_a,
    output matmul_pkg::data_t out_b,
    output matmul_pkg::data_t acc
);

    matmul_pkg::data_t a_q;
    matmul_pkg::data_t b_q;
    matmul_pkg::data_t prod;

    // Operand, product and accumulator registers make the three stages.
    // Product and sum keep only the low byte, so both wrap modulo 256
    always_ff @(posedge clk) begin
        if (clear) begin
            a_q  <= '0;
            b_q  <= '0;
            prod <= '0;
            acc  <= '0;
        end else begin
            a_q  <= in_a;
            b_q  <= in_b;
            prod <= a_q * b_q;
            acc  <= acc + prod;
        end
    end

    // The operand registers double as the forwarding path to the neighbours
    assign out_a = a_q;
    assign out_b = b_q;

endmodule

//--- hw/pe_array.sv
`timescale 1ns/10ps

module pe_array (
    input  logic             clk,
    input  logic             reset,
    input  logic             run,
    input  matmul_pkg::row_t a_edge,
    input  matmul_pkg::row_t b_edge,
    output matmul_pkg::row_t results [matmul_pkg::MAT_SIZE]
);

    localparam int N = matmul_pkg::MAT_SIZE;

    // a_link[r][c] feeds the PE at row r, column c from its left
    matmul_pkg::data_t a_link [N][N+1];
    // b_link[r][c] feeds the PE at row r, column c from above
    matmul_pkg::data_t b_link [N+1][N];
    logic              clear;

    // Accumulators start from zero on every run
    assign clear = reset || !run;

    for (genvar r = 0; r < N; r++) begin : g_row
        assign a_link[r][0] = a_edge[r];
        assign b_link[0][r] = b_edge[r];

        for (genvar c = 0; c < N; c++) begin : g_col
            processing_element i_pe (
                .clk   (clk),
                .clear (clear),
                .in_a  (a_link[r][c]),
                .in_b  (b_link[r][c]),
                .out_a (a_link[r][c+1]),
                .out_b (b_link[r+1][c]),
                .acc   (results[c][r])
            );
        end
    end

endmodule

//--- hw/matmul_sequencer.sv
`timescale 1ns/10ps

module matmul_sequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    output logic               run,
    output matmul_pkg::cycle_t cnt,
    output logic               done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LAUNCH,
        ST_RUNNING
    } state_t;

    state_t state;

    assign run = (state == ST_RUNNING);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    cnt <= '0;
                    if (start) begin
                        state <= ST_LAUNCH;
                    end
                end
                ST_LAUNCH: begin
                    cnt   <= '0;
                    state <= ST_RUNNING;
                end
                ST_RUNNING: begin
                    cnt <= cnt + 1'b1;
                    // Run stays up through the done cycle so the last C write lands
                    if (done) begin
                        state <= ST_IDLE;
                    end else if (cnt == matmul_pkg::cycle_t'(matmul_pkg::DONE_CYCLE)) begin
                        done <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hw/systolic_data_setup.sv
`timescale 1ns/10ps

module systolic_data_setup (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  matmul_pkg::cycle_t   cnt,
    input  matmul_pkg::mat_loc_t loc_a,
    input  matmul_pkg::mat_loc_t loc_b,
    input  matmul_pkg::word_t    a_word,
    input  matmul_pkg::word_t    b_word,
    output matmul_pkg::addr_t    a_addr,
    output matmul_pkg::addr_t    b_addr,
    output matmul_pkg::row_t     a_edge,
    output matmul_pkg::row_t     b_edge
);

    // Index 0 is the A operand and index 1 the B operand
    matmul_pkg::addr_t addr_q [2];
    matmul_pkg::row_t  lanes  [2];
    logic              fetch;
    logic              rd_active;
    logic              rd_valid;

    assign fetch = run && (cnt < matmul_pkg::cycle_t'(matmul_pkg::MAT_SIZE));

    // Address is presented the cycle after fetch, data one more cycle later
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            rd_active <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            rd_active <= fetch;
            rd_valid  <= rd_active;
        end
    end

    for (genvar op = 0; op < 2; op++) begin : g_op
        matmul_pkg::mat_loc_t loc;
        matmul_pkg::row_t     rd_row;

        assign loc    = (op == 0) ? loc_a : loc_b;
        assign rd_row = (op == 0) ? a_word : b_word;

        // Sits one stride below base so the first fetch lands on base
        always_ff @(posedge clk) begin
            if (reset || !fetch) begin
                addr_q[op] <= loc.base - matmul_pkg::addr_t'(loc.stride);
            end else begin
                addr_q[op] <= addr_q[op] + matmul_pkg::addr_t'(loc.stride);
            end
        end

        ////////////////////////////////
        // Diagonal skew
        ////////////////////////////////

        for (genvar i = 0; i < matmul_pkg::MAT_SIZE; i++) begin : g_lane
            matmul_pkg::data_t lane_in;

            assign lane_in = rd_valid ? rd_row[i] : '0;

            if (i == 0) begin : g_direct
                assign lanes[op][i] = lane_in;
            end else begin : g_delay
                matmul_pkg::data_t dly [i];

                always_ff @(posedge clk) begin
                    if (reset || !run) begin
                        for (int d = 0; d < i; d++) begin
                            dly[d] <= '0;
                        end
                    end else begin
                        dly[0] <= lane_in;
                        for (int d = 1; d < i; d++) begin
                            dly[d] <= dly[d-1];
                        end
                    end
                end

                assign lanes[op][i] = dly[i-1];
            end
        end
    end

    assign a_addr = addr_q[0];
    assign b_addr = addr_q[1];
    assign a_edge = lanes[0];
    assign b_edge = lanes[1];

endmodule

//--- hw/c_writeback.sv
`timescale 1ns/10ps

module c_writeback (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  matmul_pkg::cycle_t   cnt,
    input  matmul_pkg::mat_loc_t loc_c,
    input  matmul_pkg::row_t     results [matmul_pkg::MAT_SIZE],
    output matmul_pkg::mem_req_t c_req
);

    localparam int N = matmul_pkg::MAT_SIZE;

    matmul_pkg::row_t        cols [N];
    matmul_pkg::addr_t       wr_addr;
    logic                    wr_en;
    logic [$clog2(N)-1:0]    wr_idx;
    logic                    capture;

    assign capture = run && (cnt == matmul_pkg::cycle_t'(matmul_pkg::CAPTURE_CYCLE));

    ////////////////////////////////
    // Write control
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            wr_en  <= 1'b0;
            wr_idx <= '0;
        end else if (capture) begin
            wr_en  <= 1'b1;
            wr_idx <= '0;
        end else if (wr_en) begin
            wr_idx <= wr_idx + 1'b1;
            if (wr_idx == N - 1) begin
                wr_en <= 1'b0;
            end
        end
    end

    // Column 0 goes out first, the rest move down one slot per write
    always_ff @(posedge clk) begin
        if (capture) begin
            cols    <= results;
            wr_addr <= loc_c.base;
        end else if (wr_en) begin
            for (int k = 0; k < N - 1; k++) begin
                cols[k] <= cols[k+1];
            end
            wr_addr <= wr_addr + matmul_pkg::addr_t'(loc_c.stride);
        end
    end

    assign c_req = '{addr: wr_addr, wdata: matmul_pkg::word_t'(cols[0]), we: wr_en};

endmodule

//--- hw/matmul_top.sv
`timescale 1ns/10ps

module matmul_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  matmul_pkg::mat_loc_t loc_a,
    input  matmul_pkg::mat_loc_t loc_b,
    input  matmul_pkg::mat_loc_t loc_c,
    input  matmul_pkg::mem_req_t ext_a,
    input  matmul_pkg::mem_req_t ext_b,
    input  matmul_pkg::mem_req_t ext_c,
    output matmul_pkg::word_t    rdata_a,
    output matmul_pkg::word_t    rdata_b,
    output matmul_pkg::word_t    rdata_c,
    output logic                 done
);

    logic                 run;
    matmul_pkg::cycle_t   cnt;
    matmul_pkg::addr_t    a_addr;
    matmul_pkg::addr_t    b_addr;
    matmul_pkg::word_t    a_word;
    matmul_pkg::word_t    b_word;
    matmul_pkg::mem_req_t a_req;
    matmul_pkg::mem_req_t b_req;
    matmul_pkg::mem_req_t c_req;
    matmul_pkg::row_t     a_edge;
    matmul_pkg::row_t     b_edge;
    matmul_pkg::row_t     results [matmul_pkg::MAT_SIZE];

    // The multiplier only reads A and B on port 0
    assign a_req = '{addr: a_addr, wdata: '0, we: 1'b0};
    assign b_req = '{addr: b_addr, wdata: '0, we: 1'b0};

    ////////////////////////////////
    // Memories
    ////////////////////////////////

    word_ram i_ram_a (.clk(clk), .port0(a_req), .port1(ext_a), .q0(a_word), .q1(rdata_a));
    word_ram i_ram_b (.clk(clk), .port0(b_req), .port1(ext_b), .q0(b_word), .q1(rdata_b));
    word_ram i_ram_c (.clk(clk), .port0(c_req), .port1(ext_c), .q0(), .q1(rdata_c));

    ////////////////////////////////
    // Compute path
    ////////////////////////////////

    matmul_sequencer i_sequencer (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .run   (run),
        .cnt   (cnt),
        .done  (done)
    );

    systolic_data_setup i_data_setup (
        .clk    (clk),
        .reset  (reset),
        .run    (run),
        .cnt    (cnt),
        .loc_a  (loc_a),
        .loc_b  (loc_b),
        .a_word (a_word),
        .b_word (b_word),
        .a_addr (a_addr),
        .b_addr (b_addr),
        .a_edge (a_edge),
        .b_edge (b_edge)
    );

    pe_array i_pe_array (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .a_edge  (a_edge),
        .b_edge  (b_edge),
        .results (results)
    );

    c_writeback i_writeback (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .cnt     (cnt),
        .loc_c   (loc_c),
        .results (results),
        .c_req   (c_req)
    );

endmodule

//--- testbench/matmul_chk.sv
`timescale 1ns/10ps

module matmul_chk (
    input logic clk,
    input logic reset,
    input logic done,
    input logic run,
    input logic c_we
);

    int assert_fails = 0;

    //////////////////////////////
    // Sequencer and writeback
    //////////////////////////////

    // Done is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            assert_fails++;
        end

    // C is written only inside a run
    we_in_run: assert property (@(posedge clk) disable iff (reset) c_we |-> run)
        else begin
            $error("C write enable high while run is low");
            assert_fails++;
        end

    after_reset: assert property (@(posedge clk) reset |=> (!done && !c_we))
        else begin
            $error("done or C write enable high right after reset");
            assert_fails++;
        end

endmodule

bind matmul_top matmul_chk i_chk (
    .clk   (clk),
    .reset (reset),
    .done  (done),
    .run   (run),
    .c_we  (c_req.we)
);

//--- testbench/matmul_tb.sv
`timescale 1ns/10ps

module matmul_tb;

    localparam int N = matmul_pkg::MAT_SIZE;
    localparam int TIMEOUT = 200;
    localparam int NUM_CASES = 5;

    typedef enum {KIND_IDENT, KIND_FULL, KIND_RAND} kind_t;

    typedef struct {
        matmul_pkg::mat_loc_t loc_a;
        matmul_pkg::mat_loc_t loc_b;
        matmul_pkg::mat_loc_t loc_c;
        kind_t                kind;
    } case_t;

    logic                 clk;
    logic                 reset;
    logic                 start;
    matmul_pkg::mat_loc_t loc_a;
    matmul_pkg::mat_loc_t loc_b;
    matmul_pkg::mat_loc_t loc_c;
    matmul_pkg::mem_req_t ext_a;
    matmul_pkg::mem_req_t ext_b;
    matmul_pkg::mem_req_t ext_c;
    matmul_pkg::word_t    rdata_a;
    matmul_pkg::word_t    rdata_b;
    matmul_pkg::word_t    rdata_c;
    logic                 done;

    case_t             cases [NUM_CASES];
    matmul_pkg::data_t a_m [N][N];
    matmul_pkg::data_t b_m [N][N];
    matmul_pkg::data_t c_m [N][N];

    matmul_top i_matmul_top (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .loc_a   (loc_a),
        .loc_b   (loc_b),
        .loc_c   (loc_c),
        .ext_a   (ext_a),
        .ext_b   (ext_b),
        .ext_c   (ext_c),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .rdata_c (rdata_c),
        .done    (done)
    );

    always #2 clk = ~clk;

    ////////////////////////////////
    // Compare and report
    ////////////////////////////////

    task automatic check_word(string name, matmul_pkg::word_t got, matmul_pkg::word_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "word mismatch on %s", name);
        end
    endtask

    task automatic check_data(string name, matmul_pkg::data_t got, matmul_pkg::data_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "element mismatch on %s", name);
        end
    endtask

    task automatic fail_plain(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        if (i_matmul_top.i_chk.assert_fails != 0) begin
            $display("TEST FAILED");
            $fatal(1, "assertion failure in the checker");
        end
    end

    // Marker for C words the multiplier must leave alone
    function automatic matmul_pkg::word_t sentinel(matmul_pkg::addr_t addr);
        return {6'h2b, addr, 6'h15, addr};
    endfunction

    ////////////////////////////////
    // External memory ports
    ////////////////////////////////

    // Port 0 is A, 1 is B, anything else is C
    task automatic drive_port(int sel, matmul_pkg::mem_req_t req);
        case (sel)
            0: ext_a <= req;
            1: ext_b <= req;
            default: ext_c <= req;
        endcase
    endtask

    task automatic write_word(int sel, matmul_pkg::addr_t addr, matmul_pkg::word_t data);
        @(posedge clk);
        drive_port(sel, '{addr: addr, wdata: data, we: 1'b1});
        @(posedge clk);
        drive_port(sel, '{addr: addr, wdata: '0, we: 1'b0});
    endtask

    // The word appears one cycle after the address is taken
    task automatic read_word(int sel, matmul_pkg::addr_t addr, output matmul_pkg::word_t data);
        @(posedge clk);
        drive_port(sel, '{addr: addr, wdata: '0, we: 1'b0});
        @(posedge clk);
        @(negedge clk);
        case (sel)
            0: data = rdata_a;
            1: data = rdata_b;
            default: data = rdata_c;
        endcase
    endtask

    task automatic write_verify(int sel, matmul_pkg::addr_t addr, matmul_pkg::word_t data);
        matmul_pkg::word_t got;
        string             name;
        write_word(sel, addr, data);
        read_word(sel, addr, got);
        case (sel)
            0: name = "rdata_a";
            1: name = "rdata_b";
            default: name = "rdata_c";
        endcase
        check_word($sformatf("%s @0x%h", name, addr), got, data);
    endtask

    ////////////////////////////////
    // Matrices and model
    ////////////////////////////////

    task automatic make_matrices(kind_t kind);
        int acc;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                case (kind)
                    KIND_IDENT: begin
                        a_m[i][j] = (i == j) ? 8'd1 : 8'd0;
                        b_m[i][j] = matmul_pkg::data_t'($urandom);
                    end
                    KIND_FULL: begin
                        a_m[i][j] = 8'hff;
                        b_m[i][j] = 8'hff;
                    end
                    default: begin
                        a_m[i][j] = matmul_pkg::data_t'($urandom);
                        b_m[i][j] = matmul_pkg::data_t'($urandom);
                    end
                endcase
            end
        end
        // Every product element is taken modulo 256
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                acc = 0;
                for (int k = 0; k < N; k++) begin
                    acc = acc + a_m[i][k] * b_m[k][j];
                end
                c_m[i][j] = matmul_pkg::data_t'(acc);
            end
        end
    endtask

    task automatic run_case(case_t tc);
        matmul_pkg::word_t a_w;
        matmul_pkg::word_t b_w;
        matmul_pkg::word_t got;
        matmul_pkg::addr_t addr;
        logic              seen;
        int                stride;
        int                k;
        make_matrices(tc.kind);
        for (int n = 0; n < N; n++) begin
            for (int i = 0; i < N; i++) begin
                a_w[8*i +: 8] = a_m[i][n];
                b_w[8*i +: 8] = b_m[n][i];
            end
            write_verify(0, matmul_pkg::addr_t'(tc.loc_a.base + n * tc.loc_a.stride), a_w);
            write_verify(1, matmul_pkg::addr_t'(tc.loc_b.base + n * tc.loc_b.stride), b_w);
        end
        stride = tc.loc_c.stride;
        for (int off = -1; off <= N * stride; off++) begin
            addr = matmul_pkg::addr_t'(int'(tc.loc_c.base) + off);
            write_word(2, addr, sentinel(addr));
        end
        @(posedge clk);
        loc_a <= tc.loc_a;
        loc_b <= tc.loc_b;
        loc_c <= tc.loc_c;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        seen = 1'b0;
        for (int t = 0; t < TIMEOUT && !seen; t++) begin
            @(negedge clk);
            seen = done;
        end
        if (!seen) begin
            fail_plain("timeout: done never came after start");
        end
        // Columns at base plus k times stride, sentinels everywhere else
        for (int off = -1; off <= N * stride; off++) begin
            addr = matmul_pkg::addr_t'(int'(tc.loc_c.base) + off);
            read_word(2, addr, got);
            k = off / stride;
            if (off >= 0 && off % stride == 0 && k < N) begin
                for (int i = 0; i < N; i++) begin
                    check_data($sformatf("rdata_c @0x%h byte %0d", addr, i),
                               got[8*i +: 8], c_m[i][k]);
                end
            end else begin
                check_word($sformatf("rdata_c @0x%h", addr), got, sentinel(addr));
            end
        end
    endtask

    ////////////////////////////////
    // Main sequence
    ////////////////////////////////

    initial begin
        matmul_pkg::word_t got;
        clk   = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        loc_a = '0;
        loc_b = '0;
        loc_c = '0;
        ext_a = '0;
        ext_b = '0;
        ext_c = '0;
        void'($urandom(12139));
        cases = '{
            '{'{10'd0,   8'd1},  '{10'd16,  8'd1}, '{10'd32,  8'd1}, KIND_IDENT},
            '{'{10'd100, 8'd3},  '{10'd200, 8'd5}, '{10'd300, 8'd2}, KIND_RAND},
            '{'{10'd10,  8'd7},  '{10'd400, 8'd1}, '{10'd500, 8'd4}, KIND_FULL},
            '{'{10'd600, 8'd16}, '{10'd700, 8'd9}, '{10'd800, 8'd3}, KIND_RAND},
            '{'{10'd50,  8'd2},  '{10'd60,  8'd1}, '{10'd900, 8'd1}, KIND_RAND}
        };
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Idle after reset: no done pulse and no write into C
        for (int a = 1020; a < 1024; a++) begin
            write_verify(2, matmul_pkg::addr_t'(a), sentinel(matmul_pkg::addr_t'(a)));
        end
        for (int t = 0; t < 30; t++) begin
            @(negedge clk);
            if (done !== 1'b0) begin
                fail_plain("done pulsed without a start");
            end
        end
        for (int a = 1020; a < 1024; a++) begin
            read_word(2, matmul_pkg::addr_t'(a), got);
            check_word($sformatf("rdata_c @0x%h", a), got, sentinel(matmul_pkg::addr_t'(a)));
        end

        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(cases[c]);
        end

        repeat (4) @(posedge clk);
        if (i_matmul_top.i_chk.assert_fails != 0) begin
            $display("TEST FAILED");
            $fatal(1, "assertion failures in the checker");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- verilog.f
hw/matmul_pkg.sv
hw/word_ram.sv
hw/processing_element.sv
hw/pe_array.sv
hw/matmul_sequencer.sv
hw/systolic_data_setup.sv
hw/c_writeback.sv
hw/matmul_top.sv
testbench/matmul_chk.sv
testbench/matmul_tb.sv
